//--- include/biu_ahb_defines.svh
// global widths, sram depth and error window of the biu to ahb-lite subsystem
`ifndef BIU_AHB_DEFINES_SVH
`define BIU_AHB_DEFINES_SVH

////////////////////////////////////////
// datapath
////////////////////////////////////////

// data bus width, one fixed word path
`define BIU_XLEN 32

// physical address width
`define BIU_PLEN 32

////////////////////////////////////////
// sram slave
////////////////////////////////////////

// depth in 32 bit words, addresses wrap modulo the depth
`define SRAM_WORDS 256

// first byte address that answers with an ERROR response
`define ERR_BASE 32'h0001_0000

`endif

//--- rtl/biu_ahb_pkg.sv
// type definitions for ahb-lite transfer codes and core biu request fields
package biu_ahb_pkg;

  ////////////////////////////////////////
  // ahb-lite codes
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE   = 2'b00,  // no transfer
    HTRANS_BUSY   = 2'b01,  // not issued by this master
    HTRANS_NONSEQ = 2'b10,  // first beat
    HTRANS_SEQ    = 2'b11   // later beats
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE = 3'b000,
    HBURST_INCR   = 3'b001,
    HBURST_WRAP4  = 3'b010,
    HBURST_INCR4  = 3'b011,
    HBURST_WRAP8  = 3'b100,
    HBURST_INCR8  = 3'b101,
    HBURST_WRAP16 = 3'b110,
    HBURST_INCR16 = 3'b111
  } hburst_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'b000,
    HSIZE_HWORD = 3'b001,
    HSIZE_WORD  = 3'b010
  } hsize_e;

  ////////////////////////////////////////
  // core side request fields
  ////////////////////////////////////////

  // same ordering as the ahb burst codes
  typedef enum logic [2:0] {
    SINGLE = 3'b000,
    INCR   = 3'b001,  // treated as a one beat transfer
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } biu_type_e;

  typedef enum logic [2:0] {
    BYTE  = 3'b000,
    HWORD = 3'b001,
    WORD  = 3'b010
  } biu_size_e;

endpackage

//--- rtl/ahb_bus_if.sv
// ahb-lite signal bundle between the single master and the single slave
`include "biu_ahb_defines.svh"

interface ahb_bus_if import biu_ahb_pkg::*; ();

  // address phase, from master
  logic                 hsel;
  logic [`BIU_PLEN-1:0] haddr;
  logic                 hwrite;
  hsize_e               hsize;
  hburst_e              hburst;
  htrans_e              htrans;

  // data phase
  logic [`BIU_XLEN-1:0] hwdata;  // from master
  logic [`BIU_XLEN-1:0] hrdata;  // from slave
  logic                 hready;  // slave hreadyout, no mux on this bus
  logic                 hresp;   // 1 means ERROR

  modport master (
    output hsel, haddr, hwdata, hwrite, hsize, hburst, htrans,
    input  hrdata, hready, hresp
  );

  modport slave (
    input  hsel, haddr, hwdata, hwrite, hsize, hburst, htrans,
    output hrdata, hready, hresp
  );

endinterface

//--- rtl/biu_ahb_bridge.sv
// bridge turning core biu strobe requests into pipelined ahb-lite master transfers
`include "biu_ahb_defines.svh"

module biu_ahb_bridge import biu_ahb_pkg::*; (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // core biu port
  input  logic                 biu_stb_i,      // request, held until stb ack
  input  logic                 biu_we_i,
  input  logic [`BIU_PLEN-1:0] biu_adri_i,
  input  biu_size_e            biu_size_i,
  input  biu_type_e            biu_type_i,
  input  logic [`BIU_XLEN-1:0] biu_d_i,
  output logic                 biu_stb_ack_o,  // request taken this cycle
  output logic                 biu_d_ack_o,    // write beat taken this cycle
  output logic                 biu_ack_o,      // beat done
  output logic                 biu_err_o,      // burst ended by error
  output logic [`BIU_PLEN-1:0] biu_adro_o,
  output logic [`BIU_XLEN-1:0] biu_q_o,
  // ahb-lite master side
  ahb_bus_if.master            ahb_m
);

  ////////////////////////////////////////
  // field conversion
  ////////////////////////////////////////

  function automatic hsize_e size2hsize(biu_size_e sz);
    case (sz)
      BYTE:    return HSIZE_BYTE;
      HWORD:   return HSIZE_HWORD;
      default: return HSIZE_WORD;
    endcase
  endfunction

  // beats left after the first one
  function automatic logic [3:0] type2cnt(biu_type_e t);
    case (t)
      WRAP4, INCR4:   return 4'd3;
      WRAP8, INCR8:   return 4'd7;
      WRAP16, INCR16: return 4'd15;
      default:        return 4'd0;  // single and one beat incr
    endcase
  endfunction

  function automatic hburst_e type2hburst(biu_type_e t);
    case (t)
      INCR:    return HBURST_INCR;
      WRAP4:   return HBURST_WRAP4;
      INCR4:   return HBURST_INCR4;
      WRAP8:   return HBURST_WRAP8;
      INCR8:   return HBURST_INCR8;
      WRAP16:  return HBURST_WRAP16;
      INCR16:  return HBURST_INCR16;
      default: return HBURST_SINGLE;
    endcase
  endfunction

  // next word address, wrap bursts stay inside their aligned block
  function automatic logic [`BIU_PLEN-1:0] nxt_addr(logic [`BIU_PLEN-1:0] a, hburst_e b);
    logic [`BIU_PLEN-1:0] lin;
    lin = {a[`BIU_PLEN-1:2] + 1'b1, 2'b00};
    case (b)
      HBURST_WRAP4:  return {a[`BIU_PLEN-1:4], lin[3:0]};  // 16 byte block
      HBURST_WRAP8:  return {a[`BIU_PLEN-1:5], lin[4:0]};  // 32 byte block
      HBURST_WRAP16: return {a[`BIU_PLEN-1:6], lin[5:0]};  // 64 byte block
      default:       return lin;
    endcase
  endfunction

  ////////////////////////////////////////
  // address phase control
  ////////////////////////////////////////

  logic [3:0] burst_cnt;   // beats still to issue
  logic       data_ena;    // address phase on the bus
  logic       data_ena_d;  // data phase on the bus

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena     <= 1'b0;
      biu_err_o    <= 1'b0;
      burst_cnt    <= '0;
      ahb_m.hsel   <= 1'b0;
      ahb_m.haddr  <= '0;
      ahb_m.hwrite <= 1'b0;
      ahb_m.hsize  <= HSIZE_WORD;
      ahb_m.hburst <= HBURST_SINGLE;
      ahb_m.htrans <= HTRANS_IDLE;
    end else begin
      biu_err_o <= 1'b0;  // single cycle pulse
      if (ahb_m.hready) begin
        if (burst_cnt == 4'd0) begin
          if (biu_stb_i && !biu_err_o) begin  // new request, first beat
            data_ena     <= 1'b1;
            burst_cnt    <= type2cnt(biu_type_i);
            ahb_m.hsel   <= 1'b1;
            ahb_m.htrans <= HTRANS_NONSEQ;
            ahb_m.haddr  <= biu_adri_i;
            ahb_m.hwrite <= biu_we_i;
            ahb_m.hsize  <= size2hsize(biu_size_i);
            ahb_m.hburst <= type2hburst(biu_type_i);
          end else begin
            data_ena     <= 1'b0;
            ahb_m.hsel   <= 1'b0;
            ahb_m.htrans <= HTRANS_IDLE;
          end
        end else begin  // next burst beat overlaps previous data
          data_ena     <= 1'b1;
          burst_cnt    <= burst_cnt - 4'd1;
          ahb_m.htrans <= HTRANS_SEQ;
          ahb_m.haddr  <= nxt_addr(ahb_m.haddr, ahb_m.hburst);
        end
      end else if (ahb_m.hresp) begin
        // first error cycle, drop the rest of the burst
        data_ena     <= 1'b0;
        burst_cnt    <= '0;
        ahb_m.hsel   <= 1'b0;
        ahb_m.htrans <= HTRANS_IDLE;
        biu_err_o    <= 1'b1;
      end
      // otherwise wait state, address phase holds
    end
  end

  ////////////////////////////////////////
  // data phase
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      data_ena_d <= 1'b0;
    end else if (ahb_m.hready) begin
      data_ena_d <= data_ena;
    end
  end

  // write data one stage behind its address phase
  always_ff @(posedge HCLK) begin
    if (biu_d_ack_o) begin
      ahb_m.hwdata <= biu_d_i;
    end
    if (ahb_m.hready) begin
      biu_adro_o <= ahb_m.haddr;  // beat address during its data phase
    end
  end

  assign biu_q_o       = ahb_m.hrdata;
  assign biu_ack_o     = ahb_m.hready & data_ena_d & ~ahb_m.hresp;  // none on error
  assign biu_d_ack_o   = ahb_m.hready & data_ena;
  assign biu_stb_ack_o = ahb_m.hready & (burst_cnt == 4'd0) & biu_stb_i & ~biu_err_o;

endmodule

//--- rtl/ahb_sram_slave.sv
// ahb-lite sram slave with byte lane writes, wait states and an error window
`include "biu_ahb_defines.svh"

module ahb_sram_slave import biu_ahb_pkg::*; #(
  parameter int WAIT_STATES = 1  // wait cycles per data phase, 0 to 3
) (
  input logic      HCLK,
  input logic      HRESETn,
  ahb_bus_if.slave ahb_s
);

  localparam int AW = $clog2(`SRAM_WORDS);  // word index bits

  // lanes written for a given size and byte offset
  function automatic logic [3:0] lane_mask(hsize_e sz, logic [1:0] off);
    case (sz)
      HSIZE_BYTE:  return 4'b0001 << off;
      HSIZE_HWORD: return off[1] ? 4'b1100 : 4'b0011;
      default:     return 4'b1111;
    endcase
  endfunction

  logic [`BIU_XLEN-1:0] mem [`SRAM_WORDS];

  logic          addr_phase;  // valid transfer offered this cycle
  logic          dp_active;   // data phase in progress
  logic          dp_err;      // data phase inside the error window
  logic          err_second;  // second cycle of the error response
  logic [1:0]    wcnt;        // wait cycles left
  logic          dp_write;
  hsize_e        dp_size;
  logic [AW+1:0] dp_addr;     // byte address modulo the depth
  logic [AW-1:0] dp_idx;
  logic [3:0]    dp_lanes;

  assign addr_phase = ahb_s.hsel &&
                      (ahb_s.htrans == HTRANS_NONSEQ || ahb_s.htrans == HTRANS_SEQ);

  ////////////////////////////////////////
  // response control
  ////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      dp_active  <= 1'b0;
      dp_err     <= 1'b0;
      err_second <= 1'b0;
      wcnt       <= '0;
    end else if (ahb_s.hready) begin
      // previous phase done, sample the next address phase
      dp_active  <= addr_phase;
      dp_err     <= addr_phase && (ahb_s.haddr >= `ERR_BASE);
      err_second <= 1'b0;
      wcnt       <= 2'(WAIT_STATES);
    end else if (dp_err) begin
      err_second <= 1'b1;  // error takes no wait states
    end else begin
      wcnt <= wcnt - 2'd1;
    end
  end

  // idle bus is always ready
  assign ahb_s.hready = !dp_active ? 1'b1 : (dp_err ? err_second : (wcnt == 2'd0));
  assign ahb_s.hresp  = dp_active & dp_err;  // both error cycles

  ////////////////////////////////////////
  // storage
  ////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (ahb_s.hready && addr_phase) begin
      dp_write <= ahb_s.hwrite;
      dp_size  <= ahb_s.hsize;
      dp_addr  <= ahb_s.haddr[AW+1:0];
    end
  end

  assign dp_idx   = dp_addr[AW+1:2];
  assign dp_lanes = lane_mask(dp_size, dp_addr[1:0]);

  // write on the last data phase cycle, hwdata is lane aligned
  always_ff @(posedge HCLK) begin
    if (dp_active && !dp_err && dp_write && ahb_s.hready) begin
      for (int i = 0; i < 4; i++) begin
        if (dp_lanes[i]) begin
          mem[dp_idx][8*i +: 8] <= ahb_s.hwdata[8*i +: 8];
        end
      end
    end
  end

  // full word back, nothing from the error window
  assign ahb_s.hrdata = (dp_active && !dp_err) ? mem[dp_idx] : '0;

endmodule

//--- rtl/biu_ahb_top.sv
// top joining the biu bridge and the sram slave over one ahb-lite bus
`include "biu_ahb_defines.svh"

module biu_ahb_top import biu_ahb_pkg::*; (
  input  logic                 HCLK,
  input  logic                 HRESETn,
  // core biu port
  input  logic                 biu_stb_i,
  input  logic                 biu_we_i,
  input  logic [`BIU_PLEN-1:0] biu_adri_i,
  input  biu_size_e            biu_size_i,
  input  biu_type_e            biu_type_i,
  input  logic [`BIU_XLEN-1:0] biu_d_i,
  output logic                 biu_stb_ack_o,
  output logic                 biu_d_ack_o,
  output logic                 biu_ack_o,
  output logic                 biu_err_o,
  output logic [`BIU_PLEN-1:0] biu_adro_o,
  output logic [`BIU_XLEN-1:0] biu_q_o
);

  ahb_bus_if ahb ();  // single master, single slave

  ////////////////////////////////////////
  // master
  ////////////////////////////////////////

  biu_ahb_bridge u_bridge (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .biu_stb_i     (biu_stb_i),
    .biu_we_i      (biu_we_i),
    .biu_adri_i    (biu_adri_i),
    .biu_size_i    (biu_size_i),
    .biu_type_i    (biu_type_i),
    .biu_d_i       (biu_d_i),
    .biu_stb_ack_o (biu_stb_ack_o),
    .biu_d_ack_o   (biu_d_ack_o),
    .biu_ack_o     (biu_ack_o),
    .biu_err_o     (biu_err_o),
    .biu_adro_o    (biu_adro_o),
    .biu_q_o       (biu_q_o),
    .ahb_m         (ahb.master)
  );

  ////////////////////////////////////////
  // slave
  ////////////////////////////////////////

  ahb_sram_slave #(
    .WAIT_STATES (1)  // one wait cycle per beat
  ) u_sram (
    .HCLK    (HCLK),
    .HRESETn (HRESETn),
    .ahb_s   (ahb.slave)
  );

endmodule

//--- tests/tb_clkgen.sv
// testbench clock and reset source, 8 unit period, reset held low for 10 cycles
module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 unit period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;  // release away from the active edge
  end

endmodule

//--- tests/biu_ahb_sva.sv
// protocol assertions on the ahb-lite master side of the biu bridge
`include "biu_ahb_defines.svh"

module biu_ahb_sva import biu_ahb_pkg::*; (
  input logic                 HCLK,
  input logic                 HRESETn,
  input htrans_e              htrans_i,
  input logic [`BIU_PLEN-1:0] haddr_i,
  input logic                 hready_i,
  input logic                 hresp_i,
  input logic                 biu_err_i
);

  ////////////////////////////////////////
  // transfer sequencing
  ////////////////////////////////////////

  // seq only continues a burst
  a_seq_follows: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (htrans_i == HTRANS_SEQ) |->
      ($past(htrans_i) == HTRANS_NONSEQ || $past(htrans_i) == HTRANS_SEQ))
    else $error("SEQ transfer without a NONSEQ or SEQ before it");

  // address phase frozen during wait states, error cycles excluded
  a_hold_on_wait: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!hready_i && htrans_i != HTRANS_IDLE && !hresp_i) |=>
      ($stable(htrans_i) && $stable(haddr_i)))
    else $error("address phase changed while hready was low");

  ////////////////////////////////////////
  // core side and reset
  ////////////////////////////////////////

  a_err_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    biu_err_i |=> !biu_err_i)
    else $error("biu error flag longer than one cycle");

  a_idle_after_reset: assert property (@(posedge HCLK)
    $rose(HRESETn) |-> (htrans_i == HTRANS_IDLE))
    else $error("htrans not IDLE in the first cycle after reset");

endmodule

bind biu_ahb_bridge biu_ahb_sva u_sva (
  .HCLK      (HCLK),
  .HRESETn   (HRESETn),
  .htrans_i  (ahb_m.htrans),
  .haddr_i   (ahb_m.haddr),
  .hready_i  (ahb_m.hready),
  .hresp_i   (ahb_m.hresp),
  .biu_err_i (biu_err_o)
);

//--- tests/biu_ahb_tb.sv
// directed testbench for the biu bridge and sram slave with a word reference model
`include "biu_ahb_defines.svh"

module biu_ahb_tb import biu_ahb_pkg::*; ();

  localparam int TMO = 64;  // idle cycles allowed per wait

  logic                 HCLK;
  logic                 HRESETn;
  logic                 stb;
  logic                 we;
  logic [`BIU_PLEN-1:0] adri;
  biu_size_e            size;
  biu_type_e            btype;
  logic [`BIU_XLEN-1:0] wd;
  logic                 stb_ack;
  logic                 d_ack;
  logic                 ack;
  logic                 err;
  logic [`BIU_PLEN-1:0] adro;
  logic [`BIU_XLEN-1:0] q;

  logic [31:0] ref_mem [`SRAM_WORDS];  // mirror of the sram
  logic [31:0] wbuf [17];              // write beats of the next request
  logic [31:0] rdata [17];             // read data per acked beat
  logic [31:0] radr [17];              // beat address per acked beat
  logic [31:0] lfsr_state;
  int          errors;
  int          timeouts;

  tb_clkgen u_clkgen (.clk_o(HCLK), .rst_n_o(HRESETn));

  biu_ahb_top u_dut (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .biu_stb_i (stb), .biu_we_i (we), .biu_adri_i (adri), .biu_size_i (size),
    .biu_type_i (btype), .biu_d_i (wd), .biu_stb_ack_o (stb_ack), .biu_d_ack_o (d_ack),
    .biu_ack_o (ack), .biu_err_o (err), .biu_adro_o (adro), .biu_q_o (q)
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};  // one step per bit
    end
  endtask

  function automatic int beats_of(biu_type_e ty);
    case (ty)
      WRAP4, INCR4:   return 4;
      WRAP8, INCR8:   return 8;
      WRAP16, INCR16: return 16;
      default:        return 1;
    endcase
  endfunction

  // beat i of a burst, wrap bursts stay in the aligned block of beats*4 bytes
  function automatic logic [31:0] beat_addr(logic [31:0] start, biu_type_e ty, int i);
    logic [31:0] span;
    logic [31:0] lin;
    span = 32'(beats_of(ty) * 4);
    lin  = start + 32'(4 * i);
    if (ty == WRAP4 || ty == WRAP8 || ty == WRAP16) begin
      return (start & ~(span - 32'd1)) | (lin & (span - 32'd1));
    end
    return lin;
  endfunction

  // lanes from the naturally aligned container of the access size
  function automatic void model_write(logic [31:0] a, biu_size_e sz, logic [31:0] data);
    int nb;
    int first;
    nb    = (sz == BYTE) ? 1 : ((sz == HWORD) ? 2 : 4);
    first = int'(a[1:0]) & ~(nb - 1);
    for (int l = 0; l < 4; l++) begin
      if (l >= first && l < first + nb) ref_mem[a[9:2]][8*l +: 8] = data[8*l +: 8];
    end
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // one request, single or burst
  ////////////////////////////////////////

  task automatic run_burst(input logic wr, input logic [31:0] a, input biu_size_e sz,
                           input biu_type_e ty, output int n_ack, output logic got_err);
    int   n;
    int   wi;
    logic taken;
    n_ack   = 0;
    got_err = 1'b0;
    taken   = 1'b0;
    wi      = 0;
    @(posedge HCLK);
    stb   <= 1'b1;
    we    <= wr;
    adri  <= a;
    size  <= sz;
    btype <= ty;
    wd    <= wbuf[0];
    for (n = 0; n < TMO && !taken; n++) begin
      @(negedge HCLK);
      taken = stb_ack;
    end
    @(posedge HCLK);
    stb <= 1'b0;  // consumed on this edge
    if (!taken) begin
      timeouts++;
      $display("timeout: request at %h was never accepted", a);
      return;
    end
    n = 0;
    while (n_ack < beats_of(ty) && !got_err && n < TMO) begin
      @(negedge HCLK);
      n++;
      if (d_ack && wi < 16) wi++;  // next beat data follows
      if (ack) begin
        rdata[n_ack] = q;
        radr[n_ack]  = adro;
        n_ack++;
        n = 0;
      end
      if (err) got_err = 1'b1;
      @(posedge HCLK);
      wd <= wbuf[wi];
    end
    if (n >= TMO) begin
      timeouts++;
      $display("timeout: request at %h stopped after %0d beats", a, n_ack);
    end else if (!got_err) begin
      check_eq(32'(wi), 32'(n_ack), "one data ack per beat");
    end
  endtask

  task automatic do_write(input logic [31:0] a, input biu_size_e sz, input logic [31:0] data);
    int   n_ack;
    logic got_err;
    wbuf[0] = data;
    run_burst(1'b1, a, sz, SINGLE, n_ack, got_err);
    check_eq(32'(n_ack), 32'd1, "single write ack count");
    check_eq({31'd0, got_err}, 32'd0, "single write error flag");
    model_write(a, sz, data);
  endtask

  task automatic read_check(input logic [31:0] a, input biu_size_e sz, input string msg);
    int   n_ack;
    logic got_err;
    run_burst(1'b0, a, sz, SINGLE, n_ack, got_err);
    check_eq(32'(n_ack), 32'd1, {msg, " ack count"});
    check_eq({31'd0, got_err}, 32'd0, {msg, " error flag"});
    check_eq(rdata[0], ref_mem[a[9:2]], {msg, " data"});
    check_eq(radr[0], a, {msg, " beat address"});
  endtask

  task automatic expect_no_ack(input int cycles);
    for (int c = 0; c < cycles; c++) begin
      @(negedge HCLK);
      check_eq({31'd0, ack}, 32'd0, "beat ack after error");
    end
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic fill_memory();
    logic [31:0] a;
    for (int i = 0; i < `SRAM_WORDS; i++) begin
      a = 32'(i) << 2;
      do_write(a, WORD, a ^ {a[15:0], a[31:16]} ^ 32'h9e37_79b9);
    end
  endtask

  task automatic test_word_rw();
    do_write(32'h40, WORD, 32'hcafe_f00d);
    read_check(32'h40, WORD, "word read back");
  endtask

  task automatic test_lanes();
    logic [31:0] v;
    for (int o = 0; o < 4; o++) begin
      rand_bits(32, v);
      do_write(32'h80 + 32'(o), BYTE, v);
      read_check(32'h80, WORD, "byte lane merge");
    end
    for (int o = 0; o < 4; o += 2) begin
      rand_bits(32, v);
      do_write(32'h84 + 32'(o), HWORD, v);
      read_check(32'h84, WORD, "halfword lane merge");
    end
  endtask

  task automatic burst_pair(input biu_type_e ty, input logic [31:0] start);
    int          n_ack;
    int          nb;
    logic        got_err;
    logic [31:0] v;
    logic [31:0] ba;
    nb = beats_of(ty);
    for (int i = 0; i < nb; i++) begin
      rand_bits(32, v);
      wbuf[i] = v;
    end
    run_burst(1'b1, start, WORD, ty, n_ack, got_err);
    check_eq(32'(n_ack), 32'(nb), "burst write ack count");
    for (int i = 0; i < n_ack; i++) model_write(beat_addr(start, ty, i), WORD, wbuf[i]);
    run_burst(1'b0, start, WORD, ty, n_ack, got_err);
    check_eq(32'(n_ack), 32'(nb), "burst read ack count");
    for (int i = 0; i < n_ack; i++) begin
      ba = beat_addr(start, ty, i);
      check_eq(radr[i], ba, "burst beat address");
      check_eq(rdata[i], ref_mem[ba[9:2]], "burst read data");
    end
  endtask

  task automatic test_error_window();
    int          n_ack;
    logic        got_err;
    logic [31:0] v;
    run_burst(1'b0, `ERR_BASE, WORD, SINGLE, n_ack, got_err);
    check_eq({31'd0, got_err}, 32'd1, "error on read in window");
    check_eq(32'(n_ack), 32'd0, "acks on errored read");
    expect_no_ack(6);
    wbuf[0] = 32'h0bad_0bad;
    run_burst(1'b1, `ERR_BASE + 32'h20, HWORD, SINGLE, n_ack, got_err);
    check_eq({31'd0, got_err}, 32'd1, "error on write in window");
    check_eq(32'(n_ack), 32'd0, "acks on errored write");
    // sram word the errored write would alias to
    read_check(32'h20, WORD, "word untouched by errored write");
    for (int i = 0; i < 4; i++) begin
      rand_bits(32, v);
      wbuf[i] = v;
    end
    // two beats below the window, third one hits it
    run_burst(1'b1, `ERR_BASE - 32'd8, WORD, INCR4, n_ack, got_err);
    check_eq(32'(n_ack), 32'd2, "acks before burst error");
    check_eq({31'd0, got_err}, 32'd1, "burst error flag");
    for (int i = 0; i < n_ack; i++) model_write(beat_addr(`ERR_BASE - 32'd8, INCR4, i),
                                                 WORD, wbuf[i]);
    expect_no_ack(8);
    read_check(`ERR_BASE - 32'd8, WORD, "read after error beat 0");
    read_check(`ERR_BASE - 32'd4, WORD, "read after error beat 1");
  endtask

  task automatic test_random();
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] data;
    biu_size_e   sz;
    for (int i = 0; i < 40; i++) begin
      rand_bits(2, r);
      case (r[1:0])
        2'd0:    sz = BYTE;
        2'd1:    sz = HWORD;
        default: sz = WORD;
      endcase
      rand_bits(16, a);  // always below the error window
      if (sz == HWORD) a[0] = 1'b0;
      if (sz == WORD) a[1:0] = 2'b00;
      rand_bits(1, r);
      if (r[0]) begin
        rand_bits(32, data);
        do_write(a, sz, data);
      end
      read_check(a, sz, "random access");
    end
  endtask

  ////////////////////////////////////////
  // sequence
  ////////////////////////////////////////

  initial begin
    int n;
    stb        = 1'b0;
    we         = 1'b0;
    adri       = '0;
    size       = WORD;
    btype      = SINGLE;
    wd         = '0;
    errors     = 0;
    timeouts   = 0;
    lfsr_state = 32'hc3dc3023;
    for (n = 0; n < 40 && HRESETn !== 1'b1; n++) @(posedge HCLK);
    if (HRESETn !== 1'b1) begin
      timeouts++;
      $display("reset was never released");
    end
    fill_memory();
    test_word_rw();
    test_lanes();
    burst_pair(INCR4, 32'h100);
    burst_pair(WRAP8, 32'h1c8);  // wraps inside 0x1c0..0x1df
    test_error_window();
    test_random();
    $display("checks done: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
rtl/biu_ahb_pkg.sv
rtl/ahb_bus_if.sv
rtl/biu_ahb_bridge.sv
rtl/ahb_sram_slave.sv
rtl/biu_ahb_top.sv
tests/tb_clkgen.sv
tests/biu_ahb_sva.sv
tests/biu_ahb_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the biu to ahb-lite testbench with verilator, run it and check the result line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module biu_ahb_tb \
  -f verilog.f -Mdir obj_dir -o biu_ahb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/biu_ahb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

grep -q "^RESULT: PASS$" "$LOG"
if [ $? -ne 0 ]; then
  echo "pass line not found in $LOG"
  exit 1
fi
exit 0
